/* files.f */
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/asrm_uart.sv
sim/uart_checker.sv
sim/uart_asserts.sv
sim/uart_tb.sv

/* run.sh */
#!/bin/sh
# build the uart testbench with verilator, run it, decide on the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module uart_tb -f files.f -o uart_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/uart_sim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim/uart_tb.sv */
/*
  uart testbench
  - clock, reset, stimulus table filled with lcg bytes
  - bus and serial drivers on the falling edge
  - scoreboard instance, watchdog, closing report
*/
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

    localparam int          clk_freq     = 96000;
    localparam int          baud_rate    = 9600;
    localparam int          clks_per_bit = clk_freq / baud_rate;  // 10
    localparam logic [15:0] base_addr    = 16'hFF04;
    localparam logic [15:0] tx_cmd_a     = base_addr + 16'(REG_TX_CMD);
    localparam logic [15:0] tx_data_a    = base_addr + 16'(REG_TX_DATA);
    localparam logic [15:0] rx_cmd_a     = base_addr + 16'(REG_RX_CMD);
    localparam logic [15:0] rx_data_a    = base_addr + 16'(REG_RX_DATA);

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_SEND, OP_WAIT_TX} op_t;

    typedef struct {
        op_t         op;
        logic        flag;     // enable level for a write, stop bit level for a send
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] exp_val;  // expected read data
    } row_t;

    logic        clk;
    logic        reset;
    logic        enable;
    logic [15:0] addr;
    logic        write_en;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        rx;
    logic        tx;
    logic        check_rd;
    logic [15:0] exp_rd;
    logic        push_tx;
    logic [7:0]  exp_tx;
    int          check_errors;
    int          pending;
    int          tb_errors;
    logic [31:0] lcg_state;
    logic [7:0]  tx_shadow;    // what TX_DATA should hold
    logic        table_ready;
    row_t        rows[$];

    asrm_uart #(
        .word_size (16),
        .addr_size (16),
        .base_addr (base_addr),
        .clk_freq  (clk_freq),
        .baud_rate (baud_rate)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .rx       (rx),
        .tx       (tx)
    );

    uart_checker #(.word_size(16), .clks_per_bit(clks_per_bit)) scoreboard (
        .clk      (clk),
        .reset    (reset),
        .data_out (data_out),
        .tx       (tx),
        .check_rd (check_rd),
        .exp_rd   (exp_rd),
        .push_tx  (push_tx),
        .exp_tx   (exp_tx),
        .errors   (check_errors),
        .pending  (pending)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [7:0] next_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];  // upper bits mix best
    endfunction

    task automatic add_row(input op_t op, input logic flag, input logic [15:0] a,
                           input logic [15:0] d, input logic [15:0] e);
        row_t r;
        r.op      = op;
        r.flag    = flag;
        r.addr    = a;
        r.data    = d;
        r.exp_val = e;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [7:0] t0;
        logic [7:0] t1;
        logic [7:0] r0;
        logic [7:0] r1;
        logic [7:0] r2;
        logic [7:0] r3;
        lcg_state = 32'd96205;
        t0 = next_byte();
        t1 = next_byte();
        r0 = next_byte();
        r1 = next_byte();
        r2 = next_byte();
        r3 = next_byte();
        add_row(OP_READ, 1'b1, tx_cmd_a, 16'h0, 16'h0001);  // reset values
        add_row(OP_READ, 1'b1, tx_data_a, 16'h0, 16'h0000);
        add_row(OP_READ, 1'b1, rx_cmd_a, 16'h0, 16'h0000);
        add_row(OP_READ, 1'b1, rx_data_a, 16'h0, 16'h0000);
        add_row(OP_WRITE, 1'b0, tx_data_a, 16'h0033, 16'h0);  // bus not selected
        add_row(OP_WRITE, 1'b1, base_addr + 16'd4, 16'h0044, 16'h0);
        add_row(OP_WRITE, 1'b1, base_addr - 16'd4, 16'h0055, 16'h0);
        add_row(OP_READ, 1'b1, tx_data_a, 16'h0, 16'h0000);
        add_row(OP_READ, 1'b1, base_addr + 16'd4, 16'h0, 16'h0000);
        add_row(OP_READ, 1'b1, base_addr - 16'd4, 16'h0, 16'h0000);
        add_row(OP_WRITE, 1'b1, tx_data_a, 16'hA55A, 16'h0);  // upper byte dropped
        add_row(OP_READ, 1'b1, tx_data_a, 16'h0, 16'h005A);
        add_row(OP_WRITE, 1'b0, tx_cmd_a, 16'h0000, 16'h0);  // no frame may start
        add_row(OP_READ, 1'b1, tx_cmd_a, 16'h0, 16'h0001);
        add_row(OP_WRITE, 1'b1, tx_data_a, {8'h00, t0}, 16'h0);  // single transmit
        add_row(OP_WRITE, 1'b1, tx_cmd_a, 16'h0000, 16'h0);
        add_row(OP_READ, 1'b1, tx_cmd_a, 16'h0, 16'h0000);
        add_row(OP_WAIT_TX, 1'b1, tx_cmd_a, 16'h0, 16'h0);
        add_row(OP_READ, 1'b1, tx_cmd_a, 16'h0, 16'h0001);
        add_row(OP_SEND, 1'b1, 16'h0, {8'h00, r0}, 16'h0);  // single receive
        add_row(OP_READ, 1'b1, rx_cmd_a, 16'h0, 16'h0001);
        add_row(OP_READ, 1'b1, rx_data_a, 16'h0, {8'h00, r0});
        add_row(OP_WRITE, 1'b1, rx_cmd_a, 16'h0000, 16'h0);
        add_row(OP_READ, 1'b1, rx_cmd_a, 16'h0, 16'h0000);
        add_row(OP_WRITE, 1'b1, tx_data_a, {8'h00, t1}, 16'h0);  // full duplex
        add_row(OP_WRITE, 1'b1, tx_cmd_a, 16'h0000, 16'h0);
        add_row(OP_SEND, 1'b1, 16'h0, {8'h00, r1}, 16'h0);
        add_row(OP_WAIT_TX, 1'b1, tx_cmd_a, 16'h0, 16'h0);
        add_row(OP_READ, 1'b1, rx_data_a, 16'h0, {8'h00, r1});
        add_row(OP_READ, 1'b1, rx_cmd_a, 16'h0, 16'h0001);
        add_row(OP_SEND, 1'b1, 16'h0, {8'h00, r2}, 16'h0);  // unacked byte gets overwritten
        add_row(OP_READ, 1'b1, rx_data_a, 16'h0, {8'h00, r2});
        add_row(OP_WRITE, 1'b1, rx_cmd_a, 16'h0000, 16'h0);
        add_row(OP_SEND, 1'b0, 16'h0, {8'h00, r3}, 16'h0);  // low stop bit
        add_row(OP_READ, 1'b1, rx_cmd_a, 16'h0, 16'h0000);
        add_row(OP_READ, 1'b1, rx_data_a, 16'h0, {8'h00, r2});
    endtask

    // each driver starts and ends on a falling edge
    task automatic bus_write(input logic en, input logic [15:0] a, input logic [15:0] d);
        enable   = en;
        addr     = a;
        write_en = 1'b1;
        data_in  = d;
        @(negedge clk);
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a, input logic [15:0] e);
        enable   = 1'b1;
        addr     = a;
        check_rd = 1'b1;  // scoreboard compares at the next rising edge
        exp_rd   = e;
        @(negedge clk);
        enable   = 1'b0;
        check_rd = 1'b0;
    endtask

    task automatic serial_send(input logic [7:0] b, input logic stop);
        logic [FRAME_BITS-1:0] bits;
        bits = {stop, b, 1'b0};  // start bit first, lsb first
        for (int i = 0; i < FRAME_BITS; i++)
        begin
            rx = bits[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        rx = 1'b1;
    endtask

    task automatic wait_tx_idle();
        enable = 1'b1;
        addr   = tx_cmd_a;
        @(negedge clk);
        while (data_out[7:0] != 8'd1)  // watchdog bounds this
            @(negedge clk);
        enable = 1'b0;
    endtask

    task automatic final_report();
        int assert_errors;
        assert_errors = UUT.transmitter.tx_rules.fails + UUT.receiver.rx_rules.fails;
        $display("errors: %0d from checks, %0d from testbench, %0d from assertions",
                 check_errors, tb_errors, assert_errors);
        if (check_errors == 0 && tb_errors == 0 && assert_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b0;
        enable      = 1'b0;
        addr        = '0;
        write_en    = 1'b0;
        data_in     = '0;
        rx          = 1'b1;  // serial line idle
        check_rd    = 1'b0;
        exp_rd      = '0;
        push_tx     = 1'b0;
        exp_tx      = '0;
        tb_errors   = 0;
        tx_shadow   = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        foreach (rows[i])
        begin
            case (rows[i].op)
                OP_WRITE:
                begin
                    if (rows[i].flag && rows[i].addr == tx_data_a)
                        tx_shadow = rows[i].data[7:0];
                    // writing 0 to TX_CMD sends whatever TX_DATA holds
                    push_tx = rows[i].flag && rows[i].addr == tx_cmd_a
                              && rows[i].data[7:0] == 8'd0;
                    exp_tx  = tx_shadow;
                    bus_write(rows[i].flag, rows[i].addr, rows[i].data);
                    push_tx = 1'b0;
                end
                OP_READ:
                    bus_read(rows[i].addr, rows[i].exp_val);
                OP_SEND:
                    serial_send(rows[i].data[7:0], rows[i].flag);
                default:
                    wait_tx_idle();
            endcase
        end
        repeat (2 * clks_per_bit) @(negedge clk);  // let a late frame finish
        if (pending != 0)
        begin
            $display("%0d expected frame(s) never appeared on tx", pending);
            tb_errors++;
        end
        final_report();
        $finish;
    end

    // twice the worst case of about 12 bit times per row
    initial
    begin
        wait (table_ready);
        #(rows.size() * 12 * clks_per_bit * 4 * 2);
        $display("timeout: the stimulus table did not finish in time");
        tb_errors++;
        final_report();
        $finish;
    end

endmodule

/* sim/uart_asserts.sv */
/*
  protocol assertions for the serial engines
  - done strobes last one cycle, only at the end of the stop state
  - transmit line high while idle
  - no strobe while reset is held
  - count of assertion failures
*/
`timescale 1ns/1ps

module uart_asserts
    import uart_pkg::*;
#(
    parameter bit is_tx = 1'b1  // selects tx or rx state codes
)(
    input logic       clk,
    input logic       reset,
    input logic [1:0] state,
    input logic       done,
    input logic       line
);

    localparam logic [1:0] idle_state = is_tx ? 2'(TX_IDLE) : 2'(RX_IDLE);
    localparam logic [1:0] stop_state = is_tx ? 2'(TX_STOP) : 2'(RX_STOP);

    int fails;  // failed assertions so far

    initial
        fails = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
        else
        begin
            $error("done strobe held for more than one cycle");
            fails++;
        end

    // the strobe closes the frame, engine is idle right after
    done_in_stop: assert property (@(posedge clk) disable iff (!reset)
        done |-> state == stop_state ##1 state == idle_state)
        else
        begin
            $error("done strobe outside the last cycle of the stop state");
            fails++;
        end

    // only the transmitter drives a line of its own
    idle_line_high: assert property (@(posedge clk) disable iff (!reset)
        (is_tx && state == idle_state) |-> line)
        else
        begin
            $error("tx low while the transmitter is idle");
            fails++;
        end

    // state is known from the second reset cycle on
    quiet_in_reset: assert property (@(posedge clk) (!reset && $past(!reset)) |-> !done)
        else
        begin
            $error("done strobe while reset is held");
            fails++;
        end

endmodule

bind uart_tx uart_asserts #(.is_tx(1'b1)) tx_rules (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .done  (tx_done),
    .line  (tx)
);

bind uart_rx uart_asserts #(.is_tx(1'b0)) rx_rules (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .done  (rx_done),
    .line  (rx_sync)
);

/* sim/uart_checker.sv */
/*
  uart scoreboard
  - compares bus read data against expected values
  - decodes every frame on tx at mid bit
  - queue of expected tx bytes, error count
*/
`timescale 1ns/1ps

module uart_checker
    import uart_pkg::*;
#(
    parameter int word_size    = 16,
    parameter int clks_per_bit = 10
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [word_size-1:0] data_out,
    input  logic                 tx,
    input  logic                 check_rd,   // compare data_out at this edge
    input  logic [word_size-1:0] exp_rd,
    input  logic                 push_tx,    // exp_tx is the next frame
    input  logic [7:0]           exp_tx,
    output int                   errors,
    output int                   pending
);

    localparam int half = clks_per_bit / 2;

    logic [7:0]            exp_q[$];  // bytes still owed on tx
    logic [FRAME_BITS-1:0] frame;     // start, data lsb first, stop
    logic [7:0]            want;
    int                    cnt;       // cycles since start edge, -1 idle
    int                    slot;

    initial
    begin
        errors  = 0;
        pending = 0;
        cnt     = -1;
    end

    task automatic frame_done();
        if (exp_q.size() == 0)
        begin
            $display("%0t ns: a frame appeared on tx with no transmission started", $time);
            errors++;
        end
        else
        begin
            want = exp_q.pop_front();
            if (frame[0] !== 1'b0 || frame[FRAME_BITS-1] !== 1'b1)
            begin
                $display("%0t ns: bad frame on tx, start bit %b and stop bit %b",
                         $time, frame[0], frame[FRAME_BITS-1]);
                errors++;
            end
            else if (frame[DATA_BITS:1] !== want)
            begin
                $display("CHECK FAILED at %0t ns: tx byte expected %h, actual %h",
                         $time, want, frame[DATA_BITS:1]);
                errors++;
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (check_rd && data_out !== exp_rd)
        begin
            $display("CHECK FAILED at %0t ns: data_out expected %h, actual %h",
                     $time, exp_rd, data_out);
            errors++;
        end
        if (push_tx)
            exp_q.push_back(exp_tx);

        if (!reset)
            cnt = -1;
        else if (cnt >= 0)
        begin
            cnt++;
            if (cnt >= half && (cnt - half) % clks_per_bit == 0)  // middle of a bit
            begin
                slot        = (cnt - half) / clks_per_bit;
                frame[slot] = tx;
                if (slot == FRAME_BITS - 1)
                begin
                    frame_done();
                    cnt = -1;  // back to hunting, mid stop bit
                end
            end
        end
        else if (tx === 1'b0)
            cnt = 0;  // first cycle of a start bit
        pending = exp_q.size();
    end

endmodule

/* logic/asrm_uart.sv */
/*
  memory mapped uart top level
  - register block on the system bus
  - transmitter and receiver, each with its own bit timer
*/
`timescale 1ns/1ps

module asrm_uart #(
    parameter int                   word_size = 16,
    parameter int                   addr_size = 16,
    parameter logic [addr_size-1:0] base_addr = 16'hFF04,
    parameter int                   clk_freq  = 1000000,
    parameter int                   baud_rate = 9600
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic [addr_size-1:0] addr,
    input  logic                 write_en,
    input  logic [word_size-1:0] data_in,
    output logic [word_size-1:0] data_out,
    input  logic                 rx,
    output logic                 tx
);

    localparam int clks_per_bit = clk_freq / baud_rate;  // integer divide, pick exact clocks

    logic [7:0] tx_byte;
    logic       tx_start;
    logic       tx_done;
    logic [7:0] rx_byte;
    logic       rx_done;

    uart_regs #(
        .word_size (word_size),
        .addr_size (addr_size),
        .base_addr (base_addr)
    ) regs (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_done  (tx_done),
        .rx_byte  (rx_byte),
        .rx_done  (rx_done)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) transmitter (
        .clk      (clk),
        .reset    (reset),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_done  (tx_done)
    );

    uart_rx #(.clks_per_bit(clks_per_bit)) receiver (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .rx_byte (rx_byte),
        .rx_done (rx_done)
    );

endmodule

/* logic/uart_regs.sv */
/*
  uart register block
  - window decode at base_addr, four byte registers
  - bus writes merged with tx_done and rx_done strobes
  - zero extended combinational read data
*/
`timescale 1ns/1ps

module uart_regs
    import uart_pkg::*;
#(
    parameter int                   word_size = 16,
    parameter int                   addr_size = 16,
    parameter logic [addr_size-1:0] base_addr = 16'hFF04
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic [addr_size-1:0] addr,
    input  logic                 write_en,
    input  logic [word_size-1:0] data_in,
    output logic [word_size-1:0] data_out,
    output logic [7:0]           tx_byte,
    output logic                 tx_start,
    input  logic                 tx_done,
    input  logic [7:0]           rx_byte,
    input  logic                 rx_done
);

    logic [addr_size-1:0] rel_addr;  // addr - base, wraps below the window
    logic                 sel;
    logic                 wr;
    reg_offset_t          offset;
    logic [7:0]           tx_cmd;
    logic [7:0]           tx_data;
    logic [7:0]           rx_cmd;
    logic [7:0]           rx_data;
    logic [7:0]           rd_byte;

    // addresses below base wrap to large values, so one compare covers both ends
    assign rel_addr = addr - base_addr;
    assign sel      = enable && (rel_addr < addr_size'(4));
    assign wr       = sel && write_en;
    assign offset   = reg_offset_t'(rel_addr[1:0]);

    assign tx_byte  = tx_data;
    assign tx_start = (tx_cmd == 8'd0);  // held until tx_done reloads 1

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            tx_cmd  <= 8'd1;  // idle, no send pending
            tx_data <= 8'd0;
            rx_cmd  <= 8'd0;
            rx_data <= 8'd0;
        end
        else
        begin
            // engine strobes win over a bus write in the same cycle
            if (tx_done)
                tx_cmd <= 8'd1;
            else if (wr && offset == REG_TX_CMD)
                tx_cmd <= data_in[7:0];

            if (wr && offset == REG_TX_DATA)
                tx_data <= data_in[7:0];

            if (rx_done)
                rx_cmd <= 8'd1;
            else if (wr && offset == REG_RX_CMD)
                rx_cmd <= data_in[7:0];  // sw ack

            if (rx_done)
                rx_data <= rx_byte;  // overwrites an unread byte
        end
    end

    always_comb
    begin
        case (offset)
            REG_TX_CMD:  rd_byte = tx_cmd;
            REG_TX_DATA: rd_byte = tx_data;
            REG_RX_CMD:  rd_byte = rx_cmd;
            default:     rd_byte = rx_data;
        endcase
    end

    assign data_out = sel ? word_size'(rd_byte) : '0;  // upper bits always 0

endmodule

/* logic/uart_rx.sv */
/*
  uart receiver
  - two flop synchronizer on rx
  - start edge detect, half bit wait, start bit recheck
  - mid bit sampling of 8 data bits lsb first
  - stop bit check, rx_done only for a good frame
*/
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 10
)(
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_done
);

    localparam int timer_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int index_w = $clog2(DATA_BITS);
    localparam logic [timer_w-1:0] last_tick = timer_w'(clks_per_bit - 1);
    localparam logic [timer_w-1:0] half_tick = timer_w'(clks_per_bit / 2 - 1);
    localparam logic [index_w-1:0] last_bit  = index_w'(DATA_BITS - 1);

    rx_state_t          state;
    logic               rx_meta;     // first sync stage
    logic               rx_sync;     // safe to use
    logic [timer_w-1:0] bit_timer;
    logic [index_w-1:0] bit_index;
    logic [7:0]         shift_reg;   // filled from the top, lsb first
    logic               bit_end;
    logic               mid_start;

    assign bit_end   = (bit_timer == last_tick);
    assign mid_start = (bit_timer == half_tick);
    assign rx_byte   = shift_reg;
    assign rx_done   = (state == RX_STOP) && bit_end && rx_sync;  // good stop only

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_meta <= 1'b1;  // idle level
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state     <= RX_IDLE;
            bit_timer <= '0;
            bit_index <= '0;
        end
        else
        begin
            case (state)
                RX_IDLE:
                begin
                    bit_timer <= '0;
                    if (!rx_sync)
                        state <= RX_START;  // falling edge seen
                end
                RX_START:
                    if (mid_start)
                    begin
                        // later samples now land mid bit
                        bit_timer <= '0;
                        bit_index <= '0;
                        state     <= rx_sync ? RX_IDLE : RX_BITS;  // glitch check
                    end
                    else
                        bit_timer <= bit_timer + 1'b1;
                RX_BITS:
                    if (bit_end)
                    begin
                        bit_timer <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == last_bit)
                            state <= RX_STOP;
                    end
                    else
                        bit_timer <= bit_timer + 1'b1;
                RX_STOP:
                    if (bit_end)
                        state <= RX_IDLE;  // bad stop just drops the byte
                    else
                        bit_timer <= bit_timer + 1'b1;
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RX_BITS && bit_end)
            shift_reg <= {rx_sync, shift_reg[7:1]};
    end

endmodule

/* logic/uart_tx.sv */
/*
  uart transmitter
  - own bit timer, clks_per_bit cycles per bit
  - start bit, 8 data bits lsb first, stop bit
  - registered tx line, tx_done in last stop cycle
*/
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 10
)(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_done
);

    localparam int timer_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int index_w = $clog2(DATA_BITS);
    localparam logic [timer_w-1:0] last_tick = timer_w'(clks_per_bit - 1);
    localparam logic [index_w-1:0] last_bit  = index_w'(DATA_BITS - 1);

    tx_state_t          state;
    logic [timer_w-1:0] bit_timer;   // cycles into current bit
    logic [index_w-1:0] bit_index;   // data bit being sent
    logic [7:0]         shift_reg;   // bit 0 is the next data bit
    logic               tx_reg;
    logic               bit_end;

    assign bit_end = (bit_timer == last_tick);
    assign tx      = tx_reg;
    assign tx_done = (state == TX_STOP) && bit_end;  // one cycle, end of frame

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state     <= TX_IDLE;
            bit_timer <= '0;
            bit_index <= '0;
            tx_reg    <= 1'b1;  // line idles high
        end
        else
        begin
            // timer free runs inside a frame, wraps every bit
            if (state == TX_IDLE || bit_end)
                bit_timer <= '0;
            else
                bit_timer <= bit_timer + 1'b1;

            case (state)
                TX_IDLE:
                begin
                    tx_reg <= 1'b1;
                    if (tx_start)
                    begin
                        state  <= TX_START;
                        tx_reg <= 1'b0;  // start bit
                    end
                end
                TX_START:
                    if (bit_end)
                    begin
                        state     <= TX_BITS;
                        bit_index <= '0;
                        tx_reg    <= shift_reg[0];  // first data bit
                    end
                TX_BITS:
                    if (bit_end)
                    begin
                        if (bit_index == last_bit)
                        begin
                            state  <= TX_STOP;
                            tx_reg <= 1'b1;  // stop bit
                        end
                        else
                        begin
                            bit_index <= bit_index + 1'b1;
                            tx_reg    <= shift_reg[1];  // next bit after shift
                        end
                    end
                TX_STOP:
                    if (bit_end)
                        state <= TX_IDLE;
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // byte latched on leaving idle, later bus writes do not touch the frame
    always_ff @(posedge clk)
    begin
        if (state == TX_IDLE && tx_start)
            shift_reg <= tx_byte;
        else if (state == TX_BITS && bit_end)
            shift_reg <= shift_reg >> 1;
    end

endmodule

/* logic/uart_pkg.sv */
/*
  shared uart definitions
  - register offsets within the bus window
  - transmitter and receiver state encodings
  - frame constants (8N1)
*/
package uart_pkg;

    // byte offsets from base_addr
    typedef enum logic [1:0] {
        REG_TX_CMD  = 2'd0,  // write 0 to send, reads 1 when idle
        REG_TX_DATA = 2'd1,  // byte to send
        REG_RX_CMD  = 2'd2,  // 1 when a byte arrived, sw writes 0 to ack
        REG_RX_DATA = 2'd3   // last received byte, read only
    } reg_offset_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_BITS,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_BITS,
        RX_STOP
    } rx_state_t;

    localparam int DATA_BITS  = 8;   // data bits per frame, lsb first
    localparam int FRAME_BITS = 10;  // start + data + stop

endpackage
